/* spmm_cfg_pkg.sv */
package spmm_cfg_pkg;

  // ==================================================
  // Arithmetic widths
  // ==================================================
  localparam int DATA_WIDTH       = 8;
  localparam int WH_DATA_WIDTH    = 20;

  // H and W dimensions
  localparam int NUM_FEATURE_IN   = 16;
  localparam int COL_IDX_WIDTH    = 4;
  localparam int NUM_FEATURE_OUT  = 4;

  // Node info fields, row length 1 to 16
  localparam int ROW_LEN_WIDTH    = 5;
  localparam int MAX_NODES        = 168;
  localparam int NUM_NODE_WIDTH   = 8;

  // ==================================================
  // Memory sizes
  // ==================================================
  localparam int NUM_ROWS         = 8;
  localparam int H_DATA_DEPTH     = 128;
  localparam int H_DATA_ADDR_W    = 7;
  localparam int NODE_INFO_ADDR_W = 3;
  localparam int WH_ADDR_W        = 3;

  localparam int FIFO_DEPTH       = 4;

endpackage

/* spmm_types_pkg.sv */
package spmm_types_pkg;

  import spmm_cfg_pkg::*;

  // One nonzero of H
  typedef struct packed {
    logic [COL_IDX_WIDTH-1:0]      col_idx;
    logic signed [DATA_WIDTH-1:0]  value;
  } sparse_entry_t;

  // One word per row of H
  typedef struct packed {
    logic [ROW_LEN_WIDTH-1:0]   row_len;
    logic [NUM_NODE_WIDTH-1:0]  num_node;
    logic                       src_flag;
  } node_info_t;

  // Row of W selected by a column index, lane j feeds PE j
  typedef struct packed {
    logic [NUM_FEATURE_OUT-1:0][DATA_WIDTH-1:0] lane;
  } wgt_row_t;

  typedef struct packed {
    logic signed [DATA_WIDTH-1:0]  value;
    logic                          first;
    logic                          last;
  } pe_beat_t;

  typedef logic [NUM_FEATURE_OUT-1:0][WH_DATA_WIDTH-1:0] wh_res_t;

  // Wh memory word
  typedef struct packed {
    wh_res_t                    res;
    logic [NUM_NODE_WIDTH-1:0]  num_node;
    logic                       src_flag;
  } wh_row_t;

endpackage

/* sync_fifo.sv */
`timescale 1ns/1ps

module sync_fifo #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = spmm_cfg_pkg::FIFO_DEPTH
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     push_i,
  input  payload_t data_i,
  input  logic     pop_i,
  output payload_t data_o,
  output logic     full_o,
  output logic     empty_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  assign full_o  = (count == CNT_W'(DEPTH));
  assign empty_o = (count == '0);
  // Show-ahead, head entry always visible
  assign data_o  = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push_i) begin
      mem[wr_ptr] <= data_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_i) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push_i, pop_i})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n) push_i |-> !full_o);
  a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) pop_i |-> !empty_o);

endmodule

/* h_fetch.sv */
`timescale 1ns/1ps

module h_fetch (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic                                    run_i,
  output logic [spmm_cfg_pkg::H_DATA_ADDR_W-1:0]  h_data_addr_o,
  output logic [spmm_cfg_pkg::NODE_INFO_ADDR_W-1:0] node_info_addr_o,
  input  spmm_types_pkg::sparse_entry_t           h_data_i,
  input  spmm_types_pkg::node_info_t              node_info_i,
  output logic                                    entry_push_o,
  output spmm_types_pkg::sparse_entry_t           entry_o,
  input  logic                                    entry_full_i,
  output logic                                    info_push_o,
  output spmm_types_pkg::node_info_t              info_o,
  input  logic                                    info_full_i
);

  import spmm_cfg_pkg::*;

  logic [H_DATA_ADDR_W:0]    h_cnt;
  logic [NODE_INFO_ADDR_W:0] info_cnt;
  // Entries announced by fetched row lengths but not yet read
  logic [H_DATA_ADDR_W:0]    owed;
  logic [H_DATA_ADDR_W:0]    owed_add;
  logic                      entry_pend;
  logic                      info_pend;
  logic                      entry_rd;
  logic                      info_rd;

  // ==================================================
  // Read issue, one read in flight per memory
  // ==================================================
  assign info_rd  = run_i && (info_cnt < NUM_ROWS) && !info_full_i && !info_pend;
  assign entry_rd = run_i && (owed != '0) && !entry_full_i && !entry_pend;

  assign h_data_addr_o    = h_cnt[H_DATA_ADDR_W-1:0];
  assign node_info_addr_o = info_cnt[NODE_INFO_ADDR_W-1:0];

  // Read data lands one cycle after issue
  assign entry_push_o = entry_pend;
  assign entry_o      = h_data_i;
  assign info_push_o  = info_pend;
  assign info_o       = node_info_i;

  assign owed_add = info_pend ?
                    {{(H_DATA_ADDR_W + 1 - ROW_LEN_WIDTH){1'b0}}, node_info_i.row_len} : '0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      h_cnt      <= '0;
      info_cnt   <= '0;
      owed       <= '0;
      entry_pend <= 1'b0;
      info_pend  <= 1'b0;
    end else if (!run_i) begin
      // Idle between runs, next run starts at address 0
      h_cnt      <= '0;
      info_cnt   <= '0;
      owed       <= '0;
      entry_pend <= 1'b0;
      info_pend  <= 1'b0;
    end else begin
      if (info_rd) begin
        info_cnt <= info_cnt + 1'b1;
      end
      if (entry_rd) begin
        h_cnt <= h_cnt + 1'b1;
      end
      info_pend  <= info_rd;
      entry_pend <= entry_rd;
      owed       <= owed + owed_add - {{H_DATA_ADDR_W{1'b0}}, entry_rd};
    end
  end

  a_h_addr_range: assert property (@(posedge clk) disable iff (!rst_n)
    entry_rd |-> h_cnt < H_DATA_DEPTH);

endmodule

/* row_sequencer.sv */
`timescale 1ns/1ps

module row_sequencer (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  spmm_types_pkg::sparse_entry_t         entry_i,
  input  logic                                  entry_empty_i,
  output logic                                  entry_pop_o,
  input  spmm_types_pkg::node_info_t            info_i,
  input  logic                                  info_empty_i,
  output logic                                  info_pop_o,
  output logic [spmm_cfg_pkg::COL_IDX_WIDTH-1:0] wgt_addr_o,
  output logic                                  beat_vld_o,
  output spmm_types_pkg::pe_beat_t              beat_o,
  output spmm_types_pkg::node_info_t            row_info_o
);

  import spmm_cfg_pkg::*;
  import spmm_types_pkg::*;

  logic                     fire;
  logic                     first;
  logic                     last;
  logic [ROW_LEN_WIDTH-1:0] cnt;
  node_info_t               beat_info_q;

  // Both heads valid means one entry goes out this cycle
  assign fire  = !entry_empty_i && !info_empty_i;
  assign first = (cnt == '0);
  assign last  = (cnt == info_i.row_len - 1'b1);

  assign entry_pop_o = fire;
  assign info_pop_o  = fire && last;
  // W row comes back with the one-cycle read latency
  assign wgt_addr_o  = entry_i.col_idx;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt        <= '0;
      beat_vld_o <= 1'b0;
    end else begin
      beat_vld_o <= fire;
      if (fire) begin
        cnt <= last ? '0 : cnt + 1'b1;
      end
    end
  end

  // ==================================================
  // Beat and row info alignment
  // ==================================================
  always_ff @(posedge clk) begin
    if (fire) begin
      beat_o.value <= entry_i.value;
      beat_o.first <= first;
      beat_o.last  <= last;
      beat_info_q  <= info_i;
    end
    // Info follows the last beat, so it lines up with res_vld
    if (beat_vld_o && beat_o.last) begin
      row_info_o <= beat_info_q;
    end
  end

  a_row_len_legal: assert property (@(posedge clk) disable iff (!rst_n)
    fire |-> (info_i.row_len != '0) && (info_i.row_len <= NUM_FEATURE_IN));

endmodule

/* sp_pe.sv */
`timescale 1ns/1ps

module sp_pe (
  input  logic                                          clk,
  input  logic                                          rst_n,
  input  logic                                          beat_vld_i,
  input  spmm_types_pkg::pe_beat_t                      beat_i,
  input  logic signed [spmm_cfg_pkg::DATA_WIDTH-1:0]    wgt_i,
  output logic                                          res_vld_o,
  output logic signed [spmm_cfg_pkg::WH_DATA_WIDTH-1:0] res_o
);

  import spmm_cfg_pkg::*;

  logic signed [2*DATA_WIDTH-1:0]  prod;
  logic signed [WH_DATA_WIDTH-1:0] acc;
  logic signed [WH_DATA_WIDTH-1:0] base;
  logic signed [WH_DATA_WIDTH-1:0] sum_next;
  // Tracks an open row for the ordering check
  logic                            in_row;

  assign prod = $signed(beat_i.value) * wgt_i;

  always_comb begin
    if (beat_i.first) begin
      base = '0;
    end else begin
      base = acc;
    end
    sum_next = base + prod;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      res_vld_o <= 1'b0;
      in_row    <= 1'b0;
    end else begin
      res_vld_o <= beat_vld_i && beat_i.last;
      if (beat_vld_i) begin
        in_row <= !beat_i.last;
      end
    end
  end

  // Sum and result registers
  always_ff @(posedge clk) begin
    if (beat_vld_i) begin
      acc <= sum_next;
      if (beat_i.last) begin
        res_o <= sum_next;
      end
    end
  end

  a_first_after_last: assert property (@(posedge clk) disable iff (!rst_n)
    beat_vld_i && beat_i.first |-> !in_row);
  a_mid_inside_row: assert property (@(posedge clk) disable iff (!rst_n)
    beat_vld_i && !beat_i.first |-> in_row);

endmodule

/* wh_writer.sv */
`timescale 1ns/1ps

module wh_writer (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   run_i,
  input  logic                                   res_vld_i,
  input  spmm_types_pkg::wh_res_t                results_i,
  input  spmm_types_pkg::node_info_t             row_info_i,
  output logic                                   wh_we_o,
  output logic [spmm_cfg_pkg::WH_ADDR_W-1:0]     wh_addr_o,
  output spmm_types_pkg::wh_row_t                wh_data_o,
  output logic                                   rdy_o
);

  import spmm_cfg_pkg::*;

  logic [WH_ADDR_W:0] wr_cnt;

  // Write straight through, the Wh port never stalls
  assign wh_we_o            = res_vld_i;
  assign wh_addr_o          = wr_cnt[WH_ADDR_W-1:0];
  assign wh_data_o.res      = results_i;
  assign wh_data_o.num_node = row_info_i.num_node;
  assign wh_data_o.src_flag = row_info_i.src_flag;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_cnt <= '0;
      rdy_o  <= 1'b0;
    end else if (!run_i) begin
      wr_cnt <= '0;
      rdy_o  <= 1'b0;
    end else if (res_vld_i) begin
      wr_cnt <= wr_cnt + 1'b1;
      // last row of the run written
      if (wr_cnt == NUM_ROWS - 1) begin
        rdy_o <= 1'b1;
      end
    end
  end

  a_no_write_after_done: assert property (@(posedge clk) disable iff (!rst_n)
    res_vld_i |-> run_i && !rdy_o);

endmodule

/* spmm_top.sv */
`timescale 1ns/1ps

module spmm_top (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  logic                                      spmm_vld_i,
  output logic                                      spmm_rdy_o,
  output logic [spmm_cfg_pkg::H_DATA_ADDR_W-1:0]    h_data_addr_o,
  input  spmm_types_pkg::sparse_entry_t             h_data_i,
  output logic [spmm_cfg_pkg::NODE_INFO_ADDR_W-1:0] node_info_addr_o,
  input  spmm_types_pkg::node_info_t                node_info_i,
  output logic [spmm_cfg_pkg::COL_IDX_WIDTH-1:0]    wgt_addr_o,
  input  spmm_types_pkg::wgt_row_t                  wgt_row_i,
  output logic                                      wh_we_o,
  output logic [spmm_cfg_pkg::WH_ADDR_W-1:0]        wh_addr_o,
  output spmm_types_pkg::wh_row_t                   wh_data_o
);

  import spmm_cfg_pkg::*;
  import spmm_types_pkg::*;

  logic                       entry_push;
  logic                       entry_pop;
  logic                       entry_full;
  logic                       entry_empty;
  sparse_entry_t              entry_in;
  sparse_entry_t              entry_head;
  logic                       info_push;
  logic                       info_pop;
  logic                       info_full;
  logic                       info_empty;
  node_info_t                 info_in;
  node_info_t                 info_head;
  logic                       beat_vld;
  pe_beat_t                   beat;
  node_info_t                 row_info;
  wh_res_t                    results;
  logic [NUM_FEATURE_OUT-1:0] res_vld;

  // ==================================================
  // Fetch and FIFOs
  // ==================================================
  h_fetch u_fetch (
    .clk(clk), .rst_n(rst_n), .run_i(spmm_vld_i),
    .h_data_addr_o(h_data_addr_o), .node_info_addr_o(node_info_addr_o),
    .h_data_i(h_data_i), .node_info_i(node_info_i),
    .entry_push_o(entry_push), .entry_o(entry_in), .entry_full_i(entry_full),
    .info_push_o(info_push), .info_o(info_in), .info_full_i(info_full)
  );

  sync_fifo #(.payload_t(sparse_entry_t), .DEPTH(FIFO_DEPTH)) u_entry_fifo (
    .clk(clk), .rst_n(rst_n), .push_i(entry_push), .data_i(entry_in),
    .pop_i(entry_pop), .data_o(entry_head), .full_o(entry_full), .empty_o(entry_empty)
  );

  sync_fifo #(.payload_t(node_info_t), .DEPTH(FIFO_DEPTH)) u_info_fifo (
    .clk(clk), .rst_n(rst_n), .push_i(info_push), .data_i(info_in),
    .pop_i(info_pop), .data_o(info_head), .full_o(info_full), .empty_o(info_empty)
  );

  row_sequencer u_seq (
    .clk(clk), .rst_n(rst_n),
    .entry_i(entry_head), .entry_empty_i(entry_empty), .entry_pop_o(entry_pop),
    .info_i(info_head), .info_empty_i(info_empty), .info_pop_o(info_pop),
    .wgt_addr_o(wgt_addr_o), .beat_vld_o(beat_vld), .beat_o(beat), .row_info_o(row_info)
  );

  // ==================================================
  // One PE per output feature
  // ==================================================
  for (genvar j = 0; j < NUM_FEATURE_OUT; j++) begin : g_pe
    sp_pe u_pe (
      .clk(clk), .rst_n(rst_n), .beat_vld_i(beat_vld), .beat_i(beat),
      .wgt_i(wgt_row_i.lane[j]), .res_vld_o(res_vld[j]), .res_o(results[j])
    );
  end

  wh_writer u_writer (
    .clk(clk), .rst_n(rst_n), .run_i(spmm_vld_i), .res_vld_i(res_vld[0]),
    .results_i(results), .row_info_i(row_info), .wh_we_o(wh_we_o),
    .wh_addr_o(wh_addr_o), .wh_data_o(wh_data_o), .rdy_o(spmm_rdy_o)
  );

endmodule

/* spmm_tb.sv */
`timescale 1ns/1ps

module spmm_tb;

  import spmm_cfg_pkg::*;
  import spmm_types_pkg::*;

  localparam int NUM_RUNS = 2;

  logic                        clk;
  logic                        rst_n;
  logic                        spmm_vld_i;
  logic                        spmm_rdy_o;
  logic [H_DATA_ADDR_W-1:0]    h_data_addr_o;
  sparse_entry_t               h_data_i;
  logic [NODE_INFO_ADDR_W-1:0] node_info_addr_o;
  node_info_t                  node_info_i;
  logic [COL_IDX_WIDTH-1:0]    wgt_addr_o;
  wgt_row_t                    wgt_row_i;
  logic                        wh_we_o;
  logic [WH_ADDR_W-1:0]        wh_addr_o;
  wh_row_t                     wh_data_o;

  // ==================================================
  // Row table, NUM_ROWS rows per run
  // ==================================================
  // Each entry is row length, node count, source flag
  node_info_t row_table [NUM_RUNS*NUM_ROWS] = '{
    '{5'd1,  8'd12,  1'b1}, '{5'd16, 8'd167, 1'b0},
    '{5'd3,  8'd5,   1'b0}, '{5'd5,  8'd33,  1'b1},
    '{5'd2,  8'd1,   1'b1}, '{5'd8,  8'd90,  1'b0},
    '{5'd4,  8'd7,   1'b0}, '{5'd7,  8'd128, 1'b1},
    '{5'd16, 8'd64,  1'b1}, '{5'd1,  8'd2,   1'b0},
    '{5'd1,  8'd0,   1'b1}, '{5'd9,  8'd150, 1'b0},
    '{5'd12, 8'd77,  1'b1}, '{5'd2,  8'd19,  1'b1},
    '{5'd16, 8'd168, 1'b0}, '{5'd6,  8'd45,  1'b0}
  };

  // Memory contents and expected Wh words for the current run
  sparse_entry_t h_mem    [H_DATA_DEPTH];
  node_info_t    info_mem [NUM_ROWS];
  wgt_row_t      w_mem    [NUM_FEATURE_IN];
  wh_row_t       exp_rows [NUM_ROWS];

  int          run_entries;
  int          run_idx;
  int          wr_count;
  int          cycle_cnt;
  int          cycle_limit;

  spmm_top dut_i (
    .clk(clk), .rst_n(rst_n),
    .spmm_vld_i(spmm_vld_i), .spmm_rdy_o(spmm_rdy_o),
    .h_data_addr_o(h_data_addr_o), .h_data_i(h_data_i),
    .node_info_addr_o(node_info_addr_o), .node_info_i(node_info_i),
    .wgt_addr_o(wgt_addr_o), .wgt_row_i(wgt_row_i),
    .wh_we_o(wh_we_o), .wh_addr_o(wh_addr_o), .wh_data_o(wh_data_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Read-only memories, one cycle latency
  always @(posedge clk) begin
    h_data_i    <= h_mem[h_data_addr_o];
    node_info_i <= info_mem[node_info_addr_o];
    wgt_row_i   <= w_mem[wgt_addr_o];
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Error: %s expected 0x%0h actual 0x%0h", name, expected, actual);
      abort_run("Value mismatch");
    end
  endtask

  // ==================================================
  // Wh write monitor and cycle limit
  // ==================================================
  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      abort_run($sformatf("Timeout: run %0d not finished after %0d cycles", run_idx, cycle_cnt));
    end
    if (rst_n) begin
      if (spmm_rdy_o && wr_count != NUM_ROWS) begin
        abort_run("spmm_rdy_o rose before all rows were written");
      end
      if (wh_we_o) begin
        if (!spmm_vld_i) begin
          abort_run("Wh write while no run was requested");
        end
        if (wr_count >= NUM_ROWS) begin
          abort_run("Wh write after the last row of the run");
        end
        check_value($sformatf("run%0d write%0d addr", run_idx, wr_count),
                    wr_count, wh_addr_o);
        for (int j = 0; j < NUM_FEATURE_OUT; j++) begin
          check_value($sformatf("run%0d row%0d lane%0d", run_idx, wr_count, j),
                      exp_rows[wr_count].res[j], wh_data_o.res[j]);
        end
        check_value($sformatf("run%0d row%0d num_node", run_idx, wr_count),
                    exp_rows[wr_count].num_node, wh_data_o.num_node);
        check_value($sformatf("run%0d row%0d src_flag", run_idx, wr_count),
                    exp_rows[wr_count].src_flag, wh_data_o.src_flag);
        wr_count = wr_count + 1;
      end
    end
  end

  // Fill H, node info and W for run r, and work out the Wh rows
  task automatic build_run(input int r);
    int            addr;
    int            acc [NUM_FEATURE_OUT];
    node_info_t    info;
    sparse_entry_t e;
    for (int a = 0; a < H_DATA_DEPTH; a++) begin
      h_mem[a].col_idx = COL_IDX_WIDTH'(a);
      h_mem[a].value   = DATA_WIDTH'(a * 3 + 1);
    end
    for (int c = 0; c < NUM_FEATURE_IN; c++) begin
      for (int j = 0; j < NUM_FEATURE_OUT; j++) begin
        w_mem[c].lane[j] = DATA_WIDTH'($urandom);
      end
    end
    addr = 0;
    for (int row = 0; row < NUM_ROWS; row++) begin
      info          = row_table[r*NUM_ROWS + row];
      info_mem[row] = info;
      for (int j = 0; j < NUM_FEATURE_OUT; j++) begin
        acc[j] = 0;
      end
      for (int k = 0; k < int'(info.row_len); k++) begin
        e.col_idx   = COL_IDX_WIDTH'($urandom_range(NUM_FEATURE_IN - 1, 0));
        e.value     = DATA_WIDTH'($urandom);
        h_mem[addr] = e;
        addr        = addr + 1;
        // Signed product per output feature
        for (int j = 0; j < NUM_FEATURE_OUT; j++) begin
          acc[j] = acc[j] + int'($signed(e.value)) * int'($signed(w_mem[e.col_idx].lane[j]));
        end
      end
      for (int j = 0; j < NUM_FEATURE_OUT; j++) begin
        exp_rows[row].res[j] = WH_DATA_WIDTH'(acc[j]);
      end
      exp_rows[row].num_node = info.num_node;
      exp_rows[row].src_flag = info.src_flag;
    end
    run_entries = addr;
  endtask

  // One four-phase handshake over a full table
  task automatic apply_run(input int r);
    build_run(r);
    run_idx     = r;
    wr_count    = 0;
    cycle_limit = cycle_cnt + 4 * (run_entries + NUM_ROWS) + 100;
    @(posedge clk);
    spmm_vld_i <= 1'b1;
    do begin
      @(posedge clk);
    end while (!spmm_rdy_o);
    check_value($sformatf("run%0d rows written", r), NUM_ROWS, wr_count);
    // Ready holds while the request stays up
    repeat (3) begin
      @(posedge clk);
      check_value($sformatf("run%0d rdy hold", r), 1, spmm_rdy_o);
    end
    spmm_vld_i <= 1'b0;
    @(posedge clk);
    check_value($sformatf("run%0d rdy before release", r), 1, spmm_rdy_o);
    @(posedge clk);
    check_value($sformatf("run%0d rdy release", r), 0, spmm_rdy_o);
  endtask

  // ==================================================
  // Main sequence
  // ==================================================
  initial begin
    void'($urandom(17));
    rst_n       = 1'b0;
    spmm_vld_i  = 1'b0;
    h_data_i    = '0;
    node_info_i = '0;
    wgt_row_i   = '0;
    run_idx     = 0;
    wr_count    = 0;
    run_entries = 0;
    cycle_cnt   = 0;
    cycle_limit = 200;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    // No handshake yet, so nothing may happen
    repeat (3) begin
      @(posedge clk);
      check_value("idle rdy", 0, spmm_rdy_o);
      check_value("idle write enable", 0, wh_we_o);
    end
    for (int r = 0; r < NUM_RUNS; r++) begin
      apply_run(r);
    end
    $display("Result: PASSED");
    $finish;
  end

endmodule

/* project.f */
spmm_cfg_pkg.sv
spmm_types_pkg.sv
sync_fifo.sv
h_fetch.sv
row_sequencer.sv
sp_pe.sv
wh_writer.sv
spmm_top.sv
spmm_tb.sv

/* run.sh */
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f project.f --top-module spmm_tb -o spmm_sim
if [ $? -ne 0 ]; then
  echo "Compilation failed"
  exit 1
fi

sim_out=$(./obj_dir/spmm_sim 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "Result: PASSED"; then
  exit 0
fi
exit 1
